// ==== all.f ====
design/soc_pkg.sv
design/rst_sequencer.sv
design/bus_decoder.sv
design/device_table.sv
design/gpio_port.sv
design/soc_top.sv
verif/soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_sysctrl

sources:
  - design/soc_pkg.sv
  - design/rst_sequencer.sv
  - design/bus_decoder.sv
  - design/device_table.sv
  - design/gpio_port.sv
  - design/soc_top.sv
  - target: test
    files:
      - verif/soc_tb.sv

// ==== verif/soc_tb.sv ====
// Testbench for the system-control top level
// Drives the bus master port on the falling clock edge and checks reset
// sequencing, the device table, GPIO, invalid addresses and software resets
`timescale 1ns/1ps
`default_nettype none

module soc_tb import soc_pkg::*; ();

	localparam int RST_CNTR_BITSZ   = 4;
	localparam int GPIO_COUNT       = 8;
	localparam int CLK_PERIOD       = 100;
	localparam int RESET_CYCLES     = 16;
	localparam int RST_EDGES        = (1 << RST_CNTR_BITSZ) - 1;
	localparam int GPIO_WRITES      = 24;
	localparam int INVALID_ACCESSES = 16;
	localparam int POWEROFF_WATCH   = 40;
	localparam int TEST_CYCLES      = 2 * (RESET_CYCLES + RST_EDGES + 1)
		+ 2 * (DEVTBL_MAP_WORDS + 8) + 4 * GPIO_WRITES + 10
		+ 3 * INVALID_ACCESSES + 8 + 2 * (RST_EDGES + 8) + POWEROFF_WATCH + 4;
	localparam int WATCHDOG_CYCLES  = 2 * TEST_CYCLES + 200;

	logic                  clk_2x_w;
	logic                  rst_p;
	bus_op_t               bus_op;
	logic [ADDR_BITS-1:0]  bus_addr;
	logic [ARCH_BITS-1:0]  bus_wdata;
	logic [SEL_BITS-1:0]   bus_sel;
	logic [GPIO_COUNT-1:0] gp_in;
	logic [ARCH_BITS-1:0]  bus_rdata;
	logic                  bus_rdy;
	logic [GPIO_COUNT-1:0] gp_out;
	logic                  sys_rst;

	int                    errors;
	int                    checks;
	int                    edges;
	logic [31:0]           lcg_state;
	logic [ARCH_BITS-1:0]  gpio_model;
	logic [ADDR_BITS-1:0]  rd_queue[$];
	logic [ADDR_BITS-1:0]  rand_addr;
	logic [ARCH_BITS-1:0]  rand_data;
	logic [SEL_BITS-1:0]   rand_sel;

	soc_top #(
		.RST_CNTR_BITSZ(RST_CNTR_BITSZ),
		.GPIO_COUNT    (GPIO_COUNT)
	) i_soc_top (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.bus_op_i  (bus_op),
		.bus_addr_i(bus_addr),
		.bus_data_i(bus_wdata),
		.bus_sel_i (bus_sel),
		.gp_i      (gp_in),
		.bus_data_o(bus_rdata),
		.bus_rdy_o (bus_rdy),
		.gp_o      (gp_out),
		.sys_rst_o (sys_rst)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #(CLK_PERIOD / 2) clk_2x_w = ~clk_2x_w;
	end

	// GPIO outputs clear one cycle into any system reset
	gp_cleared_in_reset: assert property (
		@(posedge clk_2x_w) disable iff (rst_p) sys_rst |=> (gp_out == '0)
	) else begin
		errors++;
		$display("** Error: gp_o got %h expected %h under sys_rst_o", gp_out,
			{GPIO_COUNT{1'b0}});
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Id on even words, window bytes with the interrupt flag on odd words
	function automatic logic [ARCH_BITS-1:0] table_word_expected(input int idx);
		int                   slot;
		logic [ARCH_BITS-1:0] size;
		slot = idx / 2;
		if (idx == DEVTBL_RST_WORD || slot >= SLOT_COUNT)
			return '0;
		case (slot)
			SLOT_DEVTBL: size = ARCH_BITS'(DEVTBL_MAP_WORDS * SEL_BITS);
			SLOT_GPIO:   size = ARCH_BITS'(GPIO_MAP_WORDS * SEL_BITS);
			default:     size = '0;
		endcase
		if (idx % 2 == 0)
			return DEV_ID[slot];
		return size | ARCH_BITS'(DEV_USEINTR[slot]);
	endfunction

	function automatic logic [ARCH_BITS-1:0] expected_read(input logic [ADDR_BITS-1:0] addr);
		if (addr < ADDR_BITS'(GPIO_BASE))
			return table_word_expected(int'(addr));
		if (addr == ADDR_BITS'(GPIO_BASE))
			return ARCH_BITS'(gpio_model[GPIO_COUNT-1:0]);
		if (addr == ADDR_BITS'(GPIO_BASE + 1))
			return ARCH_BITS'(gp_in);
		return '0;
	endfunction

	function automatic logic [ARCH_BITS-1:0] merge_bytes(
		input logic [ARCH_BITS-1:0] old_word,
		input logic [ARCH_BITS-1:0] new_word,
		input logic [SEL_BITS-1:0]  sel
	);
		logic [ARCH_BITS-1:0] merged;
		merged = old_word;
		for (int b = 0; b < SEL_BITS; b++) begin
			if (sel[b])
				merged[8*b +: 8] = new_word[8*b +: 8];
		end
		return merged;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic drive_idle();
		bus_op    = PI1_OP_NONE;
		bus_addr  = '0;
		bus_wdata = '0;
		bus_sel   = '0;
	endtask

	// Entered and left on a falling edge, holds the request until rdy
	task automatic write_word(input logic [ADDR_BITS-1:0] addr,
		input logic [ARCH_BITS-1:0] data, input logic [SEL_BITS-1:0] sel);
		bus_op    = PI1_OP_WRITE;
		bus_addr  = addr;
		bus_wdata = data;
		bus_sel   = sel;
		#1;
		if (addr >= ADDR_BITS'(INVALID_BASE))
			compare_value("bus_rdy_o", bus_rdy, 1);
		while (bus_rdy !== 1'b1) begin
			@(negedge clk_2x_w);
			#1;
		end
		@(negedge clk_2x_w);
		drive_idle();
	endtask

	// Issues the queued reads back to back, each data word is due one
	// cycle after its acceptance
	task automatic run_reads();
		logic [ADDR_BITS-1:0] pend_addr;
		logic [ADDR_BITS-1:0] next_addr;
		bit                   pending;
		pending = 1'b0;
		while (rd_queue.size() > 0 || pending) begin
			if (pending) begin
				compare_value($sformatf("bus_data_o @%h", pend_addr), bus_rdata,
					expected_read(pend_addr));
				pending = 1'b0;
			end
			if (rd_queue.size() > 0) begin
				next_addr = rd_queue[0];
				bus_op    = PI1_OP_READ;
				bus_addr  = next_addr;
				#1;
				if (next_addr >= ADDR_BITS'(INVALID_BASE))
					compare_value("bus_rdy_o", bus_rdy, 1);
				if (bus_rdy === 1'b1) begin
					pending   = 1'b1;
					pend_addr = next_addr;
					void'(rd_queue.pop_front());
				end
			end else begin
				drive_idle();
			end
			@(negedge clk_2x_w);
		end
		drive_idle();
	endtask

	// Counts rising edges until sys_rst_o falls, with the bus idle on the
	// device table window
	task automatic edges_until_release(output int count);
		count = 0;
		while (sys_rst === 1'b1 && count <= 2 * RST_EDGES) begin
			compare_value("bus_rdy_o", bus_rdy, 0);
			@(negedge clk_2x_w);
			count++;
			compare_value("gp_o", gp_out, 0);
		end
		checks++;
		assert (sys_rst === 1'b0) else begin
			errors++;
			$display("sys_rst_o was not released within %0d clock edges", count);
		end
		compare_value("bus_rdy_o", bus_rdy, 1);
	endtask

	task automatic apply_board_reset();
		drive_idle();
		rst_p = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_2x_w);
		rst_p = 1'b0;
		edges_until_release(edges);
		compare_value("sys_rst_o edges after rst_p", edges, RST_EDGES);
		gpio_model = '0;
	endtask

	task automatic request_sw_reset(input logic [1:0] kind);
		write_word(ADDR_BITS'(GPIO_BASE), 32'h0000_00a5, 4'hf);
		gpio_model = merge_bytes(gpio_model, 32'h0000_00a5, 4'hf);
		compare_value("gp_o", gp_out, gpio_model[GPIO_COUNT-1:0]);
		write_word(ADDR_BITS'(DEVTBL_RST_WORD), ARCH_BITS'(kind), 4'h1);
		compare_value("sys_rst_o", sys_rst, 0);
		@(negedge clk_2x_w);
		compare_value("sys_rst_o", sys_rst, 1);
		edges_until_release(edges);
		compare_value("sys_rst_o edges after request", edges, RST_EDGES);
		gpio_model = '0;
		compare_value("gp_o", gp_out, 0);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		errors     = 0;
		checks     = 0;
		lcg_state  = 32'h373a_82e2;
		gpio_model = '0;
		rst_p      = 1'b1;
		gp_in      = '0;
		drive_idle();

		apply_board_reset();

		// Whole table back to back, then one lone read
		for (int i = 0; i < DEVTBL_MAP_WORDS; i++)
			rd_queue.push_back(ADDR_BITS'(i));
		run_reads();
		rd_queue.push_back(ADDR_BITS'(3));
		run_reads();

		for (int n = 0; n < GPIO_WRITES; n++) begin
			rand_data = next_random();
			rand_sel  = next_random() >> 28;
			write_word(ADDR_BITS'(GPIO_BASE), rand_data, rand_sel);
			gpio_model = merge_bytes(gpio_model, rand_data, rand_sel);
			compare_value("gp_o", gp_out, gpio_model[GPIO_COUNT-1:0]);
			rd_queue.push_back(ADDR_BITS'(GPIO_BASE));
			run_reads();
		end
		gp_in = next_random() >> 24;
		repeat (3) @(negedge clk_2x_w);
		for (int i = 1; i < GPIO_MAP_WORDS; i++)
			rd_queue.push_back(ADDR_BITS'(GPIO_BASE + i));
		run_reads();

		// Unmapped addresses
		for (int n = 0; n < INVALID_ACCESSES; n++) begin
			rand_addr = ADDR_BITS'(INVALID_BASE)
				+ ADDR_BITS'(next_random() % (32'h4000_0000 - INVALID_BASE));
			rd_queue.push_back(rand_addr);
		end
		run_reads();
		for (int n = 0; n < INVALID_ACCESSES; n++) begin
			rand_addr = ADDR_BITS'(INVALID_BASE)
				+ ADDR_BITS'(next_random() % (32'h4000_0000 - INVALID_BASE));
			rand_data = next_random();
			rand_sel  = next_random() >> 28;
			write_word(rand_addr, rand_data, rand_sel);
		end
		compare_value("gp_o", gp_out, gpio_model[GPIO_COUNT-1:0]);
		compare_value("sys_rst_o", sys_rst, 0);
		rd_queue.push_back(ADDR_BITS'(DEVTBL_RST_WORD));
		rd_queue.push_back(ADDR_BITS'(GPIO_BASE));
		run_reads();

		// Warm then cold
		request_sw_reset(2'd2);
		request_sw_reset(2'd3);

		// Power-off holds until the board reset
		write_word(ADDR_BITS'(DEVTBL_RST_WORD), 32'h1, 4'h1);
		compare_value("sys_rst_o", sys_rst, 0);
		repeat (POWEROFF_WATCH) begin
			@(negedge clk_2x_w);
			compare_value("sys_rst_o", sys_rst, 1);
		end
		apply_board_reset();
		rd_queue.push_back(ADDR_BITS'(0));
		rd_queue.push_back(ADDR_BITS'(DEVTBL_RST_WORD));
		run_reads();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/soc_top.sv ====
// System-control top level
// Bus master port, reset sequencer, address decoder, device table
// and GPIO port
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; #(
	parameter int RST_CNTR_BITSZ = 20,
	parameter int GPIO_COUNT     = 8
) (
	input  wire                   clk_2x_w,
	input  wire                   rst_p,
	input  wire bus_op_t          bus_op_i,
	input  wire [ADDR_BITS-1:0]   bus_addr_i,
	input  wire [ARCH_BITS-1:0]   bus_data_i,
	input  wire [SEL_BITS-1:0]    bus_sel_i,
	input  wire [GPIO_COUNT-1:0]  gp_i,
	output logic [ARCH_BITS-1:0]  bus_data_o,
	output logic                  bus_rdy_o,
	output logic [GPIO_COUNT-1:0] gp_o,
	output logic                  sys_rst_o
);

	logic                        sys_rst;
	logic                        rst0;
	logic                        rst1;

	bus_op_t                     dt_op;
	logic [DEVTBL_ADDR_BITS-1:0] dt_addr;
	logic [ARCH_BITS-1:0]        dt_wdata;
	logic [SEL_BITS-1:0]         dt_sel;
	logic [ARCH_BITS-1:0]        dt_rdata;
	logic                        dt_rdy;

	bus_op_t                     gp_op;
	logic [GPIO_ADDR_BITS-1:0]   gp_addr;
	logic [ARCH_BITS-1:0]        gp_wdata;
	logic [SEL_BITS-1:0]         gp_sel;
	logic [ARCH_BITS-1:0]        gp_rdata;
	logic                        gp_rdy;

	rst_sequencer #(
		.RST_CNTR_BITSZ(RST_CNTR_BITSZ)
	) i_rst_sequencer (
		.clk_2x_w (clk_2x_w),
		.rst_p    (rst_p),
		.rst0_i   (rst0),
		.rst1_i   (rst1),
		.sys_rst_o(sys_rst)
	);

	assign sys_rst_o = sys_rst;

	bus_decoder i_bus_decoder (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.bus_op_i  (bus_op_i),
		.bus_addr_i(bus_addr_i),
		.bus_data_i(bus_data_i),
		.bus_sel_i (bus_sel_i),
		.bus_data_o(bus_data_o),
		.bus_rdy_o (bus_rdy_o),
		.dt_op_o   (dt_op),
		.dt_addr_o (dt_addr),
		.dt_data_o (dt_wdata),
		.dt_sel_o  (dt_sel),
		.dt_data_i (dt_rdata),
		.dt_rdy_i  (dt_rdy),
		.gp_op_o   (gp_op),
		.gp_addr_o (gp_addr),
		.gp_data_o (gp_wdata),
		.gp_sel_o  (gp_sel),
		.gp_data_i (gp_rdata),
		.gp_rdy_i  (gp_rdy)
	);

	device_table i_device_table (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i(sys_rst),
		.op_i     (dt_op),
		.addr_i   (dt_addr),
		.data_i   (dt_wdata),
		.sel_i    (dt_sel),
		.data_o   (dt_rdata),
		.rdy_o    (dt_rdy),
		.rst0_o   (rst0),
		.rst1_o   (rst1)
	);

	gpio_port #(
		.GPIO_COUNT(GPIO_COUNT)
	) i_gpio_port (
		.clk_2x_w (clk_2x_w),
		.sys_rst_i(sys_rst),
		.op_i     (gp_op),
		.addr_i   (gp_addr),
		.data_i   (gp_wdata),
		.sel_i    (gp_sel),
		.data_o   (gp_rdata),
		.rdy_o    (gp_rdy),
		.gp_i     (gp_i),
		.gp_o     (gp_o)
	);

endmodule

`default_nettype wire

// ==== design/gpio_port.sv ====
// GPIO port
// Output register written byte by byte and read back, and an input
// readback through a two-flop synchroniser
`timescale 1ns/1ps
`default_nettype none

module gpio_port import soc_pkg::*; #(
	parameter int GPIO_COUNT = 8
) (
	input  wire                      clk_2x_w,
	input  wire                      sys_rst_i,
	input  wire bus_op_t             op_i,
	input  wire [GPIO_ADDR_BITS-1:0] addr_i,
	input  wire [ARCH_BITS-1:0]      data_i,
	input  wire [SEL_BITS-1:0]       sel_i,
	output logic [ARCH_BITS-1:0]     data_o,
	output logic                     rdy_o,
	input  wire [GPIO_COUNT-1:0]     gp_i,
	output logic [GPIO_COUNT-1:0]    gp_o
);

	logic [GPIO_COUNT-1:0] out_q;
	logic [GPIO_COUNT-1:0] in_meta_q;
	logic [GPIO_COUNT-1:0] in_sync_q;
	logic [ARCH_BITS-1:0]  rdata_q;
	logic                  rd_accept;
	logic                  wr_accept;

	assign rdy_o = ~sys_rst_i;

	assign rd_accept = (op_i == PI1_OP_READ) && rdy_o;
	assign wr_accept = (op_i == PI1_OP_WRITE) && rdy_o && (addr_i == '0);

	// Each output bit follows the enable of its byte lane
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			out_q <= '0;
		end else if (wr_accept) begin
			for (int i = 0; i < GPIO_COUNT; i++) begin
				if (sel_i[i / 8])
					out_q[i] <= data_i[i];
			end
		end
	end

	// Input synchroniser
	always_ff @(posedge clk_2x_w) begin
		in_meta_q <= gp_i;
		in_sync_q <= in_meta_q;
	end

	// Word 0 outputs, word 1 inputs, the rest reads 0
	always_ff @(posedge clk_2x_w) begin
		if (rd_accept) begin
			case (addr_i)
				GPIO_ADDR_BITS'(0): rdata_q <= ARCH_BITS'(out_q);
				GPIO_ADDR_BITS'(1): rdata_q <= ARCH_BITS'(in_sync_q);
				default:            rdata_q <= '0;
			endcase
		end
	end

	assign data_o = rdata_q;
	assign gp_o   = out_q;

endmodule

`default_nettype wire

// ==== design/device_table.sv ====
// Device table
// Read-only list of device ids and window sizes for software
// discovery, plus the register through which software requests
// a warm reset, a cold reset or power-off
`timescale 1ns/1ps
`default_nettype none

module device_table import soc_pkg::*; (
	input  wire                        clk_2x_w,
	input  wire                        sys_rst_i,
	input  wire bus_op_t               op_i,
	input  wire [DEVTBL_ADDR_BITS-1:0] addr_i,
	input  wire [ARCH_BITS-1:0]        data_i,
	input  wire [SEL_BITS-1:0]         sel_i,
	output logic [ARCH_BITS-1:0]       data_o,
	output logic                       rdy_o,
	output logic                       rst0_o,
	output logic                       rst1_o
);

	logic [1:0]           rst_req_q;
	logic [ARCH_BITS-1:0] rdata_q;
	logic                 rd_accept;
	logic                 wr_accept;
	logic                 rst_word_hit;

	// Held off while the system is in reset
	assign rdy_o = ~sys_rst_i;

	assign rd_accept    = (op_i == PI1_OP_READ) && rdy_o;
	assign wr_accept    = (op_i == PI1_OP_WRITE) && rdy_o;
	assign rst_word_hit = (addr_i == DEVTBL_ADDR_BITS'(DEVTBL_RST_WORD));

	// Bit 0 power-off, bit 1 reset, both together a cold reset
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rst_req_q <= 2'b00;
		end else if (wr_accept && rst_word_hit && sel_i[0]) begin
			rst_req_q <= data_i[1:0];
		end
	end

	// Registered read
	always_ff @(posedge clk_2x_w) begin
		if (rd_accept) begin
			if (rst_word_hit)
				rdata_q <= ARCH_BITS'(rst_req_q);
			else
				rdata_q <= devtbl_word(addr_i);
		end
	end

	assign data_o = rdata_q;
	assign rst0_o = rst_req_q[0];
	assign rst1_o = rst_req_q[1];

endmodule

`default_nettype wire

// ==== design/bus_decoder.sv ====
// Peripheral bus decoder
// Routes the single master to a slave by word address, returns the
// registered read data of the slot a read went to and serves the
// invalid-address slot itself
`timescale 1ns/1ps
`default_nettype none

module bus_decoder import soc_pkg::*; (
	input  wire                         clk_2x_w,
	input  wire                         rst_p,
	input  wire bus_op_t                bus_op_i,
	input  wire [ADDR_BITS-1:0]         bus_addr_i,
	input  wire [ARCH_BITS-1:0]         bus_data_i,
	input  wire [SEL_BITS-1:0]          bus_sel_i,
	output logic [ARCH_BITS-1:0]        bus_data_o,
	output logic                        bus_rdy_o,

	output bus_op_t                     dt_op_o,
	output logic [DEVTBL_ADDR_BITS-1:0] dt_addr_o,
	output logic [ARCH_BITS-1:0]        dt_data_o,
	output logic [SEL_BITS-1:0]         dt_sel_o,
	input  wire [ARCH_BITS-1:0]         dt_data_i,
	input  wire                         dt_rdy_i,

	output bus_op_t                     gp_op_o,
	output logic [GPIO_ADDR_BITS-1:0]   gp_addr_o,
	output logic [ARCH_BITS-1:0]        gp_data_o,
	output logic [SEL_BITS-1:0]         gp_sel_o,
	input  wire [ARCH_BITS-1:0]         gp_data_i,
	input  wire                         gp_rdy_i
);

	logic [SLOT_BITS-1:0] req_slot;
	logic [SLOT_BITS-1:0] rd_slot_q;
	logic [ADDR_BITS-1:0] dt_offset;
	logic [ADDR_BITS-1:0] gp_offset;
	logic                 rd_accept;

	// Address range compare
	always_comb begin
		if (bus_addr_i < ADDR_BITS'(GPIO_BASE))
			req_slot = SLOT_BITS'(SLOT_DEVTBL);
		else if (bus_addr_i < ADDR_BITS'(INVALID_BASE))
			req_slot = SLOT_BITS'(SLOT_GPIO);
		else
			req_slot = SLOT_BITS'(SLOT_INVALID);
	end

	// Word offsets inside each window
	assign dt_offset = bus_addr_i - ADDR_BITS'(DEVTBL_BASE);
	assign gp_offset = bus_addr_i - ADDR_BITS'(GPIO_BASE);
	assign dt_addr_o = dt_offset[DEVTBL_ADDR_BITS-1:0];
	assign gp_addr_o = gp_offset[GPIO_ADDR_BITS-1:0];

	// Only the selected slave sees the op
	assign dt_op_o = (req_slot == SLOT_BITS'(SLOT_DEVTBL)) ? bus_op_i : PI1_OP_NONE;
	assign gp_op_o = (req_slot == SLOT_BITS'(SLOT_GPIO)) ? bus_op_i : PI1_OP_NONE;

	assign dt_data_o = bus_data_i;
	assign dt_sel_o  = bus_sel_i;
	assign gp_data_o = bus_data_i;
	assign gp_sel_o  = bus_sel_i;

	// Invalid slot never stalls
	always_comb begin
		case (req_slot)
			SLOT_DEVTBL: bus_rdy_o = dt_rdy_i;
			SLOT_GPIO:   bus_rdy_o = gp_rdy_i;
			default:     bus_rdy_o = 1'b1;
		endcase
	end

	assign rd_accept = (bus_op_i == PI1_OP_READ) && bus_rdy_o;

	// Slot of the last accepted read, selects the data one cycle later
	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			rd_slot_q <= SLOT_BITS'(SLOT_INVALID);
		else if (rd_accept)
			rd_slot_q <= req_slot;
	end

	always_comb begin
		case (rd_slot_q)
			SLOT_DEVTBL: bus_data_o = dt_data_i;
			SLOT_GPIO:   bus_data_o = gp_data_i;
			default:     bus_data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/rst_sequencer.sv ====
// Reset sequencer
// Stretches the board reset with a down-counter, restarts it on a
// software warm or cold reset and latches a software power-off
`timescale 1ns/1ps
`default_nettype none

module rst_sequencer #(
	parameter int RST_CNTR_BITSZ = 20
) (
	input  wire  clk_2x_w,
	input  wire  rst_p,
	input  wire  rst0_i,
	input  wire  rst1_i,
	output logic sys_rst_o
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr_q;
	logic                      pwroff_q;
	logic                      sw_cold;
	logic                      sw_warm;
	logic                      sw_pwroff;
	logic                      cntr_busy;

	// Request pair from the device table
	assign sw_cold   = rst0_i & rst1_i;
	assign sw_warm   = ~rst0_i & rst1_i;
	assign sw_pwroff = rst0_i & ~rst1_i;

	assign cntr_busy = |rst_cntr_q;

	// A software request only restarts an idle counter, the request
	// register stays set for one cycle into the reset it caused
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			rst_cntr_q <= '1;
		end else if ((sw_warm || sw_cold) && !cntr_busy) begin
			rst_cntr_q <= '1;
		end else if (cntr_busy) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Power-off holds the system until the board reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			pwroff_q <= 1'b0;
		else if (sw_pwroff)
			pwroff_q <= 1'b1;
	end

	assign sys_rst_o = cntr_busy | pwroff_q;

endmodule

`default_nettype wire

// ==== design/soc_pkg.sv ====
// System-control package
// Bus widths, op codes, slave slots, the word address map and the
// contents of the device table read by software
`default_nettype none

package soc_pkg;

	localparam int ARCH_BITS = 32;
	localparam int ADDR_BITS = 30;
	localparam int SEL_BITS  = ARCH_BITS / 8;

	typedef enum logic [1:0] {
		PI1_OP_NONE  = 2'd0,
		PI1_OP_READ  = 2'd1,
		PI1_OP_WRITE = 2'd2
	} bus_op_t;

	// Slave slots, the last one takes every unmapped address
	localparam int SLOT_BITS    = 2;
	localparam int SLOT_DEVTBL  = 0;
	localparam int SLOT_GPIO    = 1;
	localparam int SLOT_INVALID = 2;
	localparam int SLOT_COUNT   = 3;

	// Word address map
	localparam int DEVTBL_MAP_WORDS = 64;
	localparam int GPIO_MAP_WORDS   = 4;
	localparam int DEVTBL_BASE      = 0;
	localparam int GPIO_BASE        = DEVTBL_BASE + DEVTBL_MAP_WORDS;
	localparam int INVALID_BASE     = GPIO_BASE + GPIO_MAP_WORDS;
	localparam int DEVTBL_ADDR_BITS = $clog2(DEVTBL_MAP_WORDS);
	localparam int GPIO_ADDR_BITS   = $clog2(GPIO_MAP_WORDS);

	localparam int DEVTBL_RST_WORD = 63;

	// Per-slot entries, slot 0 is the rightmost element
	localparam logic [SLOT_COUNT-1:0][ARCH_BITS-1:0] DEV_ID = {
		ARCH_BITS'(0), ARCH_BITS'(6), ARCH_BITS'(7)
	};
	localparam logic [SLOT_COUNT-1:0] DEV_USEINTR = 3'b010;
	// Window size in bytes
	localparam logic [SLOT_COUNT-1:0][ARCH_BITS-1:0] DEV_MAPSZ = {
		ARCH_BITS'(0),
		ARCH_BITS'(GPIO_MAP_WORDS * SEL_BITS),
		ARCH_BITS'(DEVTBL_MAP_WORDS * SEL_BITS)
	};

	// Even word holds the id, odd word the window size with the
	// interrupt flag in bit 0
	function automatic logic [ARCH_BITS-1:0] devtbl_word(
		input logic [DEVTBL_ADDR_BITS-1:0] word_idx
	);
		int unsigned slot;
		logic [ARCH_BITS-1:0] word;
		slot = int'(word_idx) / 2;
		word = '0;
		if (slot < SLOT_COUNT) begin
			if (word_idx[0] == 1'b0)
				word = DEV_ID[slot];
			else
				word = DEV_MAPSZ[slot] | ARCH_BITS'(DEV_USEINTR[slot]);
		end
		return word;
	endfunction

endpackage

`default_nettype wire
